// File: source/eth_pkg.sv
`default_nettype none

package eth_pkg;

   typedef logic [7:0]  eth_byte_t;
   typedef logic [3:0]  eth_nibble_t;
   typedef logic [31:0] eth_crc_t;
   typedef logic [47:0] mac_addr_t;

   // start-of-frame delimiter as seen on the byte bus
   localparam eth_byte_t ETH_SFD = 8'hD5;

   localparam int MAC_ADDR_LEN = 6;
   localparam int FCS_LEN      = 4;

   // reflected IEEE 802.3 polynomial
   localparam eth_crc_t CRC_POLY    = 32'hEDB88320;
   // register content after a good frame plus its fcs
   localparam eth_crc_t CRC_RESIDUE = 32'hDEBB20E3;

endpackage

`default_nettype wire

// File: source/rxbuf_pkg.sv
`default_nettype none

package rxbuf_pkg;

   localparam int BUF_AW    = 11;
   localparam int BUF_DEPTH = 2 ** BUF_AW;

   typedef logic [BUF_AW-1:0] buf_addr_t;
   // one bit wider than the address so a full buffer still counts
   typedef logic [11:0]       frame_len_t;

endpackage

`default_nettype wire

// File: source/eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
   input  wire logic                RX_CLK,
   input  wire logic                rx_rst,
   input  wire logic                start,
   input  wire logic                data_en,
   input  wire eth_pkg::eth_byte_t  data_in,
   output eth_pkg::eth_crc_t        crc
);

   // one byte through the reflected polynomial lsb first
   function automatic eth_pkg::eth_crc_t crc_next(eth_pkg::eth_crc_t c,
                                                   eth_pkg::eth_byte_t d);
      eth_pkg::eth_crc_t r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         if (r[0] ^ d[i]) begin
            r = (r >> 1) ^ eth_pkg::CRC_POLY;
         end else begin
            r = r >> 1;
         end
      end
      return r;
   endfunction

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc <= '1;
      end else if (start) begin
         crc <= '1;
      end else if (data_en) begin
         crc <= crc_next(crc, data_in);
      end
   end

endmodule

`default_nettype wire

// File: source/eth_rx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_framer #(
   parameter eth_pkg::mac_addr_t STATION_MAC  = 48'h02_00_00_00_00_01,
   parameter bit                 ACCEPT_BCAST = 1'b1
) (
   input  wire logic                  RX_CLK,
   input  wire logic                  rx_rst,
   input  wire logic                  rx_dv,
   input  wire eth_pkg::eth_nibble_t  rx_data,
   input  wire logic                  frame_ack,
   output logic                       wr_en,
   output rxbuf_pkg::buf_addr_t       wr_addr,
   output eth_pkg::eth_byte_t         wr_data,
   output logic                       frame_ready,
   output rxbuf_pkg::frame_len_t      rcvd_len,
   output logic                       crc_good,
   output logic                       addr_hit
);

   typedef enum logic [1:0] {HUNT, DATA, HOLD, DRAIN} state_t;

   state_t                state;
   logic                  phase;
   rxbuf_pkg::frame_len_t cnt;
   eth_pkg::eth_byte_t    sh;
   eth_pkg::eth_byte_t    byte_in;
   eth_pkg::mac_addr_t    dest_q;
   eth_pkg::eth_crc_t     crc_val;

   // new nibble goes above the previous one
   assign byte_in = {rx_data, sh[7:4]};
   assign wr_data = sh;

   always_ff @(posedge RX_CLK) begin
      if (rx_dv) begin
         sh <= byte_in;
      end
      if (state == DATA && rx_dv && phase &&
          cnt < rxbuf_pkg::frame_len_t'(eth_pkg::MAC_ADDR_LEN)) begin
         dest_q <= {dest_q[39:0], byte_in};
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state       <= HUNT;
         phase       <= 1'b0;
         cnt         <= '0;
         wr_en       <= 1'b0;
         wr_addr     <= '0;
         frame_ready <= 1'b0;
         rcvd_len    <= '0;
         crc_good    <= 1'b0;
         addr_hit    <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         case (state)
            HUNT: begin
               phase <= 1'b0;
               cnt   <= '0;
               if (rx_dv && byte_in == eth_pkg::ETH_SFD) begin
                  state <= DATA;
               end
            end
            DATA: begin
               if (!rx_dv) begin
                  state <= HOLD;
               end else begin
                  phase <= ~phase;
                  // second nibble completes the byte
                  if (phase) begin
                     wr_en   <= 1'b1;
                     wr_addr <= rxbuf_pkg::buf_addr_t'(cnt);
                     cnt     <= cnt + 1'b1;
                  end
               end
            end
            HOLD: begin
               if (!frame_ready) begin
                  frame_ready <= 1'b1;
                  rcvd_len    <= cnt;
                  crc_good    <= (crc_val == eth_pkg::CRC_RESIDUE);
                  addr_hit    <= (dest_q == STATION_MAC) ||
                                 (ACCEPT_BCAST && dest_q == '1);
               end else if (frame_ack) begin
                  frame_ready <= 1'b0;
                  // a frame that started while held is dropped whole
                  state       <= rx_dv ? DRAIN : HUNT;
               end
            end
            DRAIN: begin
               if (!rx_dv) begin
                  state <= HUNT;
               end
            end
            default: state <= HUNT;
         endcase
      end
   end

   eth_crc32 crc0 (
      .RX_CLK  (RX_CLK),
      .rx_rst  (rx_rst),
      .start   (state == HUNT),
      .data_en (wr_en),
      .data_in (wr_data),
      .crc     (crc_val)
   );

endmodule

`default_nettype wire

// File: source/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
   parameter int BUF_DEPTH = 2048
) (
   input  wire logic                  RX_CLK,
   input  wire logic                  wr_en,
   input  wire rxbuf_pkg::buf_addr_t  wr_addr,
   input  wire eth_pkg::eth_byte_t    wr_data,
   input  wire rxbuf_pkg::buf_addr_t  rd_addr,
   output eth_pkg::eth_byte_t         rd_data
);

   eth_pkg::eth_byte_t mem [BUF_DEPTH];

   always_ff @(posedge RX_CLK) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      // one cycle read latency
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: source/frame_reader.sv
`timescale 1ns/1ps
`default_nettype none

module frame_reader (
   input  wire logic                   RX_CLK,
   input  wire logic                   rx_rst,
   input  wire logic                   frame_ready,
   input  wire rxbuf_pkg::frame_len_t  rcvd_len,
   input  wire logic                   crc_good,
   input  wire logic                   addr_hit,
   input  wire eth_pkg::eth_byte_t     rd_data,
   output rxbuf_pkg::buf_addr_t        rd_addr,
   output logic                        frame_ack,
   output logic                        out_valid,
   output eth_pkg::eth_byte_t          out_data,
   output logic                        frame_done,
   output rxbuf_pkg::frame_len_t       frame_len,
   output logic                        crc_ok,
   output logic                        dest_match
);

   typedef enum logic [1:0] {IDLE, READ, DONE} state_t;

   state_t                state;
   logic                  rd_vld;
   rxbuf_pkg::frame_len_t payload_len;
   rxbuf_pkg::buf_addr_t  last_addr;

   // fcs stays in the buffer
   assign payload_len = rcvd_len - rxbuf_pkg::frame_len_t'(eth_pkg::FCS_LEN);
   assign last_addr   = rxbuf_pkg::buf_addr_t'(payload_len - 1'b1);
   assign out_data    = rd_data;

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state      <= IDLE;
         rd_addr    <= '0;
         rd_vld     <= 1'b0;
         out_valid  <= 1'b0;
         frame_done <= 1'b0;
         frame_ack  <= 1'b0;
         frame_len  <= '0;
         crc_ok     <= 1'b0;
         dest_match <= 1'b0;
      end else begin
         out_valid  <= rd_vld;
         frame_done <= 1'b0;
         frame_ack  <= 1'b0;
         case (state)
            IDLE: begin
               // ready is still high in the cycle right after the ack
               if (frame_ready && !frame_ack) begin
                  state   <= READ;
                  rd_addr <= '0;
                  rd_vld  <= 1'b1;
               end
            end
            READ: begin
               if (rd_addr == last_addr) begin
                  rd_vld <= 1'b0;
                  state  <= DONE;
               end else begin
                  rd_addr <= rd_addr + 1'b1;
               end
            end
            DONE: begin
               frame_done <= 1'b1;
               frame_ack  <= 1'b1;
               frame_len  <= payload_len;
               crc_ok     <= crc_good;
               dest_match <= addr_hit;
               state      <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/eth_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top #(
   parameter eth_pkg::mac_addr_t STATION_MAC  = 48'h02_00_00_00_00_01,
   parameter bit                 ACCEPT_BCAST = 1'b1
) (
   input  wire logic                  RX_CLK,
   input  wire logic                  rx_rst,
   input  wire logic                  rx_dv,
   input  wire eth_pkg::eth_nibble_t  rx_data,
   output logic                       out_valid,
   output eth_pkg::eth_byte_t         out_data,
   output logic                       frame_done,
   output rxbuf_pkg::frame_len_t      frame_len,
   output logic                       crc_ok,
   output logic                       dest_match
);

   logic                  wr_en;
   rxbuf_pkg::buf_addr_t  wr_addr;
   eth_pkg::eth_byte_t    wr_data;
   rxbuf_pkg::buf_addr_t  rd_addr;
   eth_pkg::eth_byte_t    rd_data;
   logic                  frame_ready;
   logic                  frame_ack;
   rxbuf_pkg::frame_len_t rcvd_len;
   logic                  crc_good;
   logic                  addr_hit;

   eth_rx_framer #(
      .STATION_MAC  (STATION_MAC),
      .ACCEPT_BCAST (ACCEPT_BCAST)
   ) framer0 (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .rx_dv       (rx_dv),
      .rx_data     (rx_data),
      .frame_ack   (frame_ack),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .frame_ready (frame_ready),
      .rcvd_len    (rcvd_len),
      .crc_good    (crc_good),
      .addr_hit    (addr_hit)
   );

   frame_buffer #(
      .BUF_DEPTH (rxbuf_pkg::BUF_DEPTH)
   ) buf0 (
      .RX_CLK  (RX_CLK),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   frame_reader reader0 (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .frame_ready (frame_ready),
      .rcvd_len    (rcvd_len),
      .crc_good    (crc_good),
      .addr_hit    (addr_hit),
      .rd_data     (rd_data),
      .rd_addr     (rd_addr),
      .frame_ack   (frame_ack),
      .out_valid   (out_valid),
      .out_data    (out_data),
      .frame_done  (frame_done),
      .frame_len   (frame_len),
      .crc_ok      (crc_ok),
      .dest_match  (dest_match)
   );

endmodule

`default_nettype wire

// File: dv/eth_rx_properties.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_properties (
   input wire logic                  RX_CLK,
   input wire logic                  rx_rst,
   input wire logic                  out_valid,
   input wire eth_pkg::eth_byte_t    out_data,
   input wire logic                  frame_done,
   input wire rxbuf_pkg::frame_len_t frame_len,
   input wire logic                  crc_ok,
   input wire logic                  dest_match
);

   int unsigned fail_count = 0;

   a_valid_vs_done: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      !(out_valid && frame_done))
      else begin
         $error("out_valid and frame_done high in the same cycle");
         fail_count++;
      end

   a_done_pulse: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      frame_done |=> !frame_done)
      else begin
         $error("frame_done held for more than one cycle");
         fail_count++;
      end

   // buffer content is only defined while a byte is strobed
   a_known: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      !$isunknown({out_valid, frame_done, frame_len, crc_ok, dest_match}) &&
      (!out_valid || !$isunknown(out_data)))
      else begin
         $error("unknown value on a DUT output");
         fail_count++;
      end

endmodule

bind eth_rx_top eth_rx_properties props0 (
   .RX_CLK     (RX_CLK),
   .rx_rst     (rx_rst),
   .out_valid  (out_valid),
   .out_data   (out_data),
   .frame_done (frame_done),
   .frame_len  (frame_len),
   .crc_ok     (crc_ok),
   .dest_match (dest_match)
);

`default_nettype wire

// File: dv/eth_rx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_checker (
   input wire logic                  RX_CLK,
   input wire logic                  rx_rst,
   input wire logic                  out_valid,
   input wire eth_pkg::eth_byte_t    out_data,
   input wire logic                  frame_done,
   input wire rxbuf_pkg::frame_len_t frame_len,
   input wire logic                  crc_ok,
   input wire logic                  dest_match
);

   eth_pkg::eth_byte_t exp_bytes[$];
   string              exp_names[$];
   int                 exp_lens[$];
   // {crc_ok, dest_match}
   logic [1:0]         exp_flags[$];
   int                 byte_idx      = 0;
   int                 mismatch_errs = 0;
   int                 other_errs    = 0;
   int                 done_count    = 0;

   task automatic expect_byte(eth_pkg::eth_byte_t b);
      exp_bytes.push_back(b);
   endtask

   task automatic expect_frame(string name, int len, logic crc, logic dest);
      exp_names.push_back(name);
      exp_lens.push_back(len);
      exp_flags.push_back({crc, dest});
   endtask

   task automatic check_value(string name, string what, int exp, int act);
      if (exp != act) begin
         $display("MISMATCH %s %s expected %0h actual %0h", name, what, exp, act);
         mismatch_errs++;
      end
   endtask

   always @(posedge RX_CLK) begin
      if (!rx_rst && out_valid) begin
         if (exp_names.size() == 0 || exp_bytes.size() == 0) begin
            $display("ERROR: out_valid high while no byte was expected");
            other_errs++;
         end else begin
            check_value(exp_names[0], $sformatf("byte %0d", byte_idx),
                        exp_bytes.pop_front(), out_data);
            byte_idx++;
         end
      end
      if (!rx_rst && frame_done) begin
         if (exp_names.size() == 0) begin
            $display("ERROR: frame_done arrived while no frame was expected");
            other_errs++;
         end else begin
            check_value(exp_names[0], "byte count", exp_lens[0], byte_idx);
            check_value(exp_names[0], "frame_len", exp_lens[0], frame_len);
            check_value(exp_names[0], "crc_ok", exp_flags[0][1], crc_ok);
            check_value(exp_names[0], "dest_match", exp_flags[0][0], dest_match);
            // drop what is left of a short stream
            while (byte_idx < exp_lens[0] && exp_bytes.size() > 0) begin
               void'(exp_bytes.pop_front());
               byte_idx++;
            end
            void'(exp_names.pop_front());
            void'(exp_lens.pop_front());
            void'(exp_flags.pop_front());
            done_count++;
         end
         byte_idx = 0;
      end
   end

endmodule

`default_nettype wire

// File: dv/eth_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_tb;

   localparam int          CLK_PERIOD = 20;
   localparam int          TIMEOUT    = 4000;
   localparam logic [31:0] SEED       = 32'd26963;
   localparam logic [47:0] STATION    = 48'h02_00_00_00_00_01;
   localparam logic [47:0] SOURCE     = 48'h02_11_22_33_44_55;

   logic                  RX_CLK;
   logic                  rx_rst;
   logic                  rx_dv;
   eth_pkg::eth_nibble_t  rx_data;
   logic                  out_valid;
   eth_pkg::eth_byte_t    out_data;
   logic                  frame_done;
   rxbuf_pkg::frame_len_t frame_len;
   logic                  crc_ok;
   logic                  dest_match;

   logic [31:0]        rng;
   eth_pkg::eth_byte_t frame_q[$];
   int                 frames_sent  = 0;
   int                 timeout_errs = 0;
   int                 end_errs     = 0;

   eth_rx_top #(
      .STATION_MAC  (STATION),
      .ACCEPT_BCAST (1'b1)
   ) dut0 (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .rx_dv      (rx_dv),
      .rx_data    (rx_data),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .frame_done (frame_done),
      .frame_len  (frame_len),
      .crc_ok     (crc_ok),
      .dest_match (dest_match)
   );

   eth_rx_checker chk0 (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .frame_done (frame_done),
      .frame_len  (frame_len),
      .crc_ok     (crc_ok),
      .dest_match (dest_match)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #(CLK_PERIOD / 2) RX_CLK = ~RX_CLK;
   end

   function automatic logic [31:0] xorshift(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // fcs over frame_q as it goes on the wire
   function automatic logic [31:0] frame_fcs();
      logic [31:0] c;
      c = 32'hFFFF_FFFF;
      foreach (frame_q[i]) begin
         c = c ^ {24'h0, frame_q[i]};
         for (int b = 0; b < 8; b++) begin
            c = (c >> 1) ^ (32'hEDB8_8320 & {32{c[0]}});
         end
      end
      return ~c;
   endfunction

   task automatic idle(int n);
      repeat (n) begin
         @(negedge RX_CLK);
         rx_dv   = 1'b0;
         rx_data = 4'h0;
      end
   endtask

   task automatic send_byte(eth_pkg::eth_byte_t b);
      @(negedge RX_CLK);
      rx_dv   = 1'b1;
      rx_data = b[3:0];
      @(negedge RX_CLK);
      rx_data = b[7:4];
   endtask

   task automatic build_frame(string kind, int len);
      logic [47:0] dest;
      dest = (kind == "broadcast") ? '1 : (kind == "own") ? STATION : STATION ^ 48'h6;
      frame_q.delete();
      for (int i = 0; i < 6; i++) begin
         frame_q.push_back(dest[47-8*i -: 8]);
      end
      for (int i = 0; i < 6; i++) begin
         frame_q.push_back(SOURCE[47-8*i -: 8]);
      end
      frame_q.push_back(8'h08);
      frame_q.push_back(8'h00);
      repeat (len) begin
         rng = xorshift(rng);
         frame_q.push_back(rng[7:0]);
      end
   endtask

   task automatic send_frame(logic bad_fcs);
      logic [31:0] fcs;
      fcs = frame_fcs() ^ (bad_fcs ? 32'h8 : 32'h0);
      repeat (7) send_byte(8'h55);
      send_byte(8'hD5);
      foreach (frame_q[i]) begin
         send_byte(frame_q[i]);
      end
      for (int i = 0; i < 4; i++) begin
         send_byte(fcs[8*i +: 8]);
      end
      idle(1);
   endtask

   task automatic wait_done(string name, int target);
      int n;
      n = 0;
      while (chk0.done_count < target && n < TIMEOUT) begin
         @(negedge RX_CLK);
         n++;
      end
      if (chk0.done_count < target) begin
         $display("ERROR: test %s got no frame_done within %0d cycles", name, TIMEOUT);
         timeout_errs++;
      end
   endtask

   initial begin
      int    fd;
      int    len;
      int    bad_fcs;
      int    drop;
      int    exp_crc;
      int    exp_dest;
      int    errs;
      string line;
      string name;
      string kind;
      rx_rst  = 1'b1;
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      rng     = SEED;
      repeat (4) @(negedge RX_CLK);
      rx_rst = 1'b0;
      idle(8);
      fd = $fopen("dv/eth_rx_stimulus.txt", "r");
      if (fd == 0) begin
         $display("ERROR: stimulus file could not be opened");
         end_errs++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%s %s %d %d %d %d %d", name, kind, len, bad_fcs,
                        drop, exp_crc, exp_dest) == 7) begin
               build_frame(kind, len);
               foreach (frame_q[i]) begin
                  chk0.expect_byte(frame_q[i]);
               end
               chk0.expect_frame(name, frame_q.size(), exp_crc[0], exp_dest[0]);
               frames_sent++;
               send_frame(bad_fcs != 0);
               // second frame lands while the first is read out
               if (drop != 0) begin
                  idle(6);
                  build_frame(kind, len);
                  send_frame(1'b0);
               end
               wait_done(name, frames_sent);
               idle(12);
            end
         end
         $fclose(fd);
      end
      idle(100);
      if (frames_sent == 0 || chk0.done_count != frames_sent || chk0.exp_names.size() != 0) begin
         $display("ERROR: %0d frames sent but %0d frame_done pulses seen",
                  frames_sent, chk0.done_count);
         end_errs++;
      end
      errs = chk0.mismatch_errs + chk0.other_errs + timeout_errs + end_errs +
             int'(dut0.props0.fail_count);
      $display("errors: mismatch %0d, protocol %0d, timeout %0d, end %0d, assertion %0d",
               chk0.mismatch_errs, chk0.other_errs, timeout_errs, end_errs,
               dut0.props0.fail_count);
      if (errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/eth_rx_stimulus.txt
# name kind length bad_fcs drop crc_ok dest_match
# kind is own, broadcast or other and length counts payload bytes only
own_min own 46 0 0 1 1
bcast_min broadcast 46 0 0 1 1
other_min other 46 0 0 1 0
own_badfcs own 64 1 0 0 1
other_badfcs other 100 1 0 0 0
own_mid own 512 0 0 1 1
bcast_long broadcast 1000 0 0 1 1
own_drop own 200 0 1 1 1
after_drop own 60 0 0 1 1
own_max own 1500 0 0 1 1
bcast_drop broadcast 46 0 1 1 1
after_drop2 other 300 0 0 1 0
own_1499 own 1499 0 0 1 1
bcast_badfcs broadcast 47 1 0 0 1
other_max other 1500 0 0 1 0
own_last own 46 0 0 1 1

// File: flist.f
source/eth_pkg.sv
source/rxbuf_pkg.sv
source/eth_crc32.sv
source/eth_rx_framer.sv
source/frame_buffer.sv
source/frame_reader.sv
source/eth_rx_top.sv
dv/eth_rx_properties.sv
dv/eth_rx_checker.sv
dv/eth_rx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the MII receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module eth_rx_tb -f flist.f -o eth_rx_sim

./obj_dir/eth_rx_sim | tee sim.log

if grep -qx "TB PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
